//--- verilog/kiwi_pkg.sv
package kiwi_pkg;

    localparam int NUM_REGS = 32;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    typedef logic [4:0] reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // register-register format
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } inst_r_t;

    // register-immediate format
    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } inst_i_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

endpackage

//--- verilog/kiwi_if.sv
`timescale 1ns/100ps

interface kiwi_uop_if;
    logic               valid;
    kiwi_pkg::reg_idx_t rs1;
    kiwi_pkg::reg_idx_t rs2;
    kiwi_pkg::reg_idx_t rd;
    logic               use_imm;
    logic               uses_rs2;
    // sign extended to 64 bits and cut to XLEN by the receiver
    logic [63:0]        imm;
    kiwi_pkg::alu_op_e  op;

    modport dec (
        output valid,
        output rs1,
        output rs2,
        output rd,
        output use_imm,
        output uses_rs2,
        output imm,
        output op
    );

    modport opnd (
        input valid,
        input rs1,
        input rs2,
        input rd,
        input use_imm,
        input imm,
        input op
    );

    modport sb (
        input valid,
        input rs1,
        input rs2,
        input uses_rs2,
        input rd
    );
endinterface

interface kiwi_exe_if #(
    parameter int XLEN = 64
);
    logic               valid;
    kiwi_pkg::alu_op_e  op;
    logic [XLEN-1:0]    src_a;
    logic [XLEN-1:0]    src_b;
    kiwi_pkg::reg_idx_t rd;

    modport issue (output valid, output op, output src_a, output src_b, output rd);
    modport exe   (input valid, input op, input src_a, input src_b, input rd);
endinterface

//--- verilog/kiwi_decoder.sv
`timescale 1ns/100ps

module kiwi_decoder (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            inst_valid_i,
    input  kiwi_pkg::inst_u inst_i,
    input  logic            stall_i,
    output logic            inst_ready_o,
    kiwi_uop_if.dec         uop
);

    logic              is_op;
    logic              is_op_imm;
    logic              alt;
    logic              legal;
    kiwi_pkg::alu_op_e op_d;

    assign is_op     = (inst_i.r.opcode == kiwi_pkg::OPC_OP);
    assign is_op_imm = (inst_i.i.opcode == kiwi_pkg::OPC_OP_IMM);

    // bit 30 selects SUB and SRA but in OP-IMM only the right shift
    assign alt = is_op ? inst_i.r.funct7[5]
                       : (inst_i.i.imm[10] && (inst_i.i.funct3 == 3'b101));

    // funct7 0100000 exists only for SUB and SRA
    assign legal = is_op_imm ||
                   (is_op && ((inst_i.r.funct7 == 7'b0000000) ||
                              ((inst_i.r.funct7 == 7'b0100000) &&
                               ((inst_i.r.funct3 == 3'b000) ||
                                (inst_i.r.funct3 == 3'b101)))));

    always_comb begin
        case (inst_i.r.funct3)
            3'b000:  op_d = alt ? kiwi_pkg::ALU_SUB : kiwi_pkg::ALU_ADD;
            3'b001:  op_d = kiwi_pkg::ALU_SLL;
            3'b010:  op_d = kiwi_pkg::ALU_SLT;
            3'b011:  op_d = kiwi_pkg::ALU_SLTU;
            3'b100:  op_d = kiwi_pkg::ALU_XOR;
            3'b101:  op_d = alt ? kiwi_pkg::ALU_SRA : kiwi_pkg::ALU_SRL;
            3'b110:  op_d = kiwi_pkg::ALU_OR;
            default: op_d = kiwi_pkg::ALU_AND;
        endcase
    end

    // held uop under stall blocks the next word
    assign inst_ready_o = !(uop.valid && stall_i);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            uop.valid <= 1'b0;
        end else if (inst_ready_o) begin
            uop.valid <= inst_valid_i && legal;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_ready_o && inst_valid_i) begin
            uop.rs1      <= inst_i.r.rs1;
            uop.rs2      <= inst_i.r.rs2;
            uop.rd       <= inst_i.r.rd;
            uop.op       <= op_d;
            uop.use_imm  <= is_op_imm;
            uop.uses_rs2 <= is_op;
            uop.imm      <= {{52{inst_i.i.imm[11]}}, inst_i.i.imm};
        end
    end

    // a stalled uop must reach the operand stage unchanged
    a_hold_stable: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (uop.valid && stall_i) |=>
            $stable({uop.valid, uop.rs1, uop.rs2, uop.rd, uop.op,
                     uop.use_imm, uop.uses_rs2, uop.imm})
    );

endmodule

//--- verilog/kiwi_scoreboard.sv
`timescale 1ns/100ps

module kiwi_scoreboard (
    input  logic               clk,
    input  logic               arst_n_i,
    kiwi_uop_if.sb             uop,
    input  logic               wb_valid_i,
    input  kiwi_pkg::reg_idx_t wb_rd_i,
    output logic               stall_o
);

    logic [kiwi_pkg::NUM_REGS-1:0] pending_q;
    logic                          issue;
    logic                          clear;
    logic                          issued_q;
    kiwi_pkg::reg_idx_t            issued_rd_q;

    // read after write on rs1, or on rs2 when the uop reads it
    assign stall_o = uop.valid &&
                     (pending_q[uop.rs1] || (uop.uses_rs2 && pending_q[uop.rs2]));

    assign issue = uop.valid && !stall_o;

    // a younger writer of the same rd still in the ALU keeps the bit
    assign clear = wb_valid_i && (wb_rd_i != '0) &&
                   !(issued_q && (issued_rd_q == wb_rd_i));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q <= '0;
            issued_q  <= 1'b0;
        end else begin
            if (clear) begin
                pending_q[wb_rd_i] <= 1'b0;
            end
            // set wins over a clear of the same register
            if (issue && (uop.rd != '0)) begin
                pending_q[uop.rd] <= 1'b1;
            end
            issued_q <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            issued_rd_q <= uop.rd;
        end
    end

    a_clear_was_set: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (wb_valid_i && (wb_rd_i != '0)) |-> pending_q[wb_rd_i]
    );

    a_x0_never_pending: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !pending_q[0]
    );

endmodule

//--- verilog/kiwi_operands.sv
`timescale 1ns/100ps

module kiwi_operands #(
    parameter int XLEN = 64
) (
    input  logic               clk,
    input  logic               arst_n_i,
    kiwi_uop_if.opnd           uop,
    input  logic               stall_i,
    input  logic               wb_valid_i,
    input  kiwi_pkg::reg_idx_t wb_rd_i,
    input  logic [XLEN-1:0]    wb_value_i,
    kiwi_exe_if.issue          exe
);

    logic [XLEN-1:0] regs_q [kiwi_pkg::NUM_REGS];
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic            issue;

    // x0 is never written, so it reads zero after reset
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < kiwi_pkg::NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_valid_i && (wb_rd_i != '0)) begin
            regs_q[wb_rd_i] <= wb_value_i;
        end
    end

    assign rs1_val = regs_q[uop.rs1];
    assign rs2_val = regs_q[uop.rs2];

    // stall leaves a bubble in the ALU stage
    assign issue = uop.valid && !stall_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exe.valid <= 1'b0;
        end else begin
            exe.valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            exe.op    <= uop.op;
            exe.rd    <= uop.rd;
            exe.src_a <= rs1_val;
            exe.src_b <= uop.use_imm ? uop.imm[XLEN-1:0] : rs2_val;
        end
    end

    a_no_issue_on_stall: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        stall_i |=> !exe.valid
    );

endmodule

//--- verilog/kiwi_alu.sv
`timescale 1ns/100ps

module kiwi_alu #(
    parameter int XLEN = 64
) (
    input  logic               clk,
    input  logic               arst_n_i,
    kiwi_exe_if.exe            exe,
    output logic               wb_valid_o,
    output kiwi_pkg::reg_idx_t wb_rd_o,
    output logic [XLEN-1:0]    wb_value_o
);

    localparam int SHW = $clog2(XLEN);

    logic [SHW-1:0]  shamt;
    logic            lt_s;
    logic            lt_u;
    logic [XLEN-1:0] result;

    // low log2(XLEN) bits only
    assign shamt = exe.src_b[SHW-1:0];

    assign lt_s = $signed(exe.src_a) < $signed(exe.src_b);
    assign lt_u = exe.src_a < exe.src_b;

    always_comb begin
        case (exe.op)
            kiwi_pkg::ALU_ADD:  result = exe.src_a + exe.src_b;
            kiwi_pkg::ALU_SUB:  result = exe.src_a - exe.src_b;
            kiwi_pkg::ALU_SLL:  result = exe.src_a << shamt;
            kiwi_pkg::ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_s};
            kiwi_pkg::ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_u};
            kiwi_pkg::ALU_XOR:  result = exe.src_a ^ exe.src_b;
            kiwi_pkg::ALU_SRL:  result = exe.src_a >> shamt;
            kiwi_pkg::ALU_SRA:  result = $signed(exe.src_a) >>> shamt;
            kiwi_pkg::ALU_OR:   result = exe.src_a | exe.src_b;
            kiwi_pkg::ALU_AND:  result = exe.src_a & exe.src_b;
            default:            result = '0;
        endcase
    end

    // write-back register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= exe.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (exe.valid) begin
            wb_rd_o    <= exe.rd;
            wb_value_o <= result;
        end
    end

    a_wb_valid_known: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !$isunknown(wb_valid_o)
    );

endmodule

//--- verilog/kiwi_core.sv
`timescale 1ns/100ps

module kiwi_core #(
    parameter int XLEN = 64
) (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               inst_valid_i,
    input  kiwi_pkg::inst_u    inst_i,
    output logic               inst_ready_o,
    output logic               wb_valid_o,
    output kiwi_pkg::reg_idx_t wb_rd_o,
    output logic [XLEN-1:0]    wb_value_o
);

    logic               stall;
    logic               wb_valid;
    kiwi_pkg::reg_idx_t wb_rd;
    logic [XLEN-1:0]    wb_value;

    kiwi_uop_if                 uop_if ();
    kiwi_exe_if #(.XLEN(XLEN)) exe_if ();

    kiwi_decoder u_decoder (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .stall_i      (stall),
        .inst_ready_o (inst_ready_o),
        .uop          (uop_if.dec)
    );

    kiwi_scoreboard u_scoreboard (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .uop        (uop_if.sb),
        .wb_valid_i (wb_valid),
        .wb_rd_i    (wb_rd),
        .stall_o    (stall)
    );

    kiwi_operands #(
        .XLEN (XLEN)
    ) u_operands (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .uop        (uop_if.opnd),
        .stall_i    (stall),
        .wb_valid_i (wb_valid),
        .wb_rd_i    (wb_rd),
        .wb_value_i (wb_value),
        .exe        (exe_if.issue)
    );

    kiwi_alu #(
        .XLEN (XLEN)
    ) u_alu (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .exe        (exe_if.exe),
        .wb_valid_o (wb_valid),
        .wb_rd_o    (wb_rd),
        .wb_value_o (wb_value)
    );

    assign wb_valid_o = wb_valid;
    assign wb_rd_o    = wb_rd;
    assign wb_value_o = wb_value;

endmodule

//--- tb/tb_kiwi_ref.svh
`ifndef TB_KIWI_REF_SVH
`define TB_KIWI_REF_SVH

logic [31:0]     lfsr_state;
logic [XLEN-1:0] model_regs [kiwi_pkg::NUM_REGS];

// fibonacci lfsr x^32 + x^22 + x^2 + x + 1 stepped once per bit taken
function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        r          = {r[62:0], fb};
    end
    return r;
endfunction

function automatic kiwi_pkg::reg_idx_t rand_reg();
    return 5'(rand_bits(5));
endfunction

function automatic kiwi_pkg::inst_u op_inst(input int k, input kiwi_pkg::reg_idx_t rs1,
                                            input kiwi_pkg::reg_idx_t rs2,
                                            input kiwi_pkg::reg_idx_t rd);
    // funct3 of ADD SUB SLL SLT SLTU XOR SRL SRA OR AND from the lowest slot up
    logic [29:0]     f3_table;
    kiwi_pkg::inst_u w;
    f3_table   = {3'd7, 3'd6, 3'd5, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0, 3'd0};
    w.r.opcode = kiwi_pkg::OPC_OP;
    w.r.funct3 = f3_table[3*k +: 3];
    w.r.funct7 = (k == 1 || k == 7) ? 7'b0100000 : 7'b0000000;
    w.r.rs1    = rs1;
    w.r.rs2    = rs2;
    w.r.rd     = rd;
    return w;
endfunction

function automatic kiwi_pkg::inst_u imm_inst(input int k, input kiwi_pkg::reg_idx_t rs1,
                                             input logic [11:0] imm,
                                             input kiwi_pkg::reg_idx_t rd);
    // funct3 of ADDI SLTI SLTIU XORI ORI ANDI SLLI SRLI SRAI from the lowest slot up
    logic [26:0]     f3_table;
    kiwi_pkg::inst_u w;
    f3_table   = {3'd5, 3'd5, 3'd1, 3'd7, 3'd6, 3'd4, 3'd3, 3'd2, 3'd0};
    w.i.opcode = kiwi_pkg::OPC_OP_IMM;
    w.i.funct3 = f3_table[3*k +: 3];
    w.i.rs1    = rs1;
    w.i.rd     = rd;
    w.i.imm    = imm;
    // shifts keep only shamt and the SRAI bit
    if (k >= 6) begin
        w.i.imm          = '0;
        w.i.imm[SHW-1:0] = imm[SHW-1:0];
        w.i.imm[10]      = (k == 8);
    end
    return w;
endfunction

// lui, auipc and two opcodes outside the base set
function automatic kiwi_pkg::inst_u other_inst();
    kiwi_pkg::inst_u w;
    w          = 32'(rand_bits(32));
    w.r.opcode = {2'(rand_bits(2)), 5'b10111};
    return w;
endfunction

function automatic bit ref_execute(input kiwi_pkg::inst_u w,
                                   output kiwi_pkg::reg_idx_t rd,
                                   output logic [XLEN-1:0] value);
    logic            is_op;
    logic            alt;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    int              sh;
    is_op = (w.r.opcode == kiwi_pkg::OPC_OP);
    // bit 30 of the word in both formats
    alt   = w.r.funct7[5];
    a     = model_regs[w.r.rs1];
    b     = is_op ? model_regs[w.r.rs2] : {{(XLEN-12){w.i.imm[11]}}, w.i.imm};
    sh    = int'(b[SHW-1:0]);
    rd    = w.r.rd;
    value = '0;
    if (!is_op && (w.i.opcode != kiwi_pkg::OPC_OP_IMM)) begin
        return 1'b0;
    end
    // only SUB and SRA may set bit 30
    if (is_op && (((w.r.funct7 & 7'b1011111) != 7'b0) ||
                  (alt && w.r.funct3 != 3'b000 && w.r.funct3 != 3'b101))) begin
        return 1'b0;
    end
    case (w.r.funct3)
        3'b000:  value = (is_op && alt) ? a - b : a + b;
        3'b001:  value = a << sh;
        3'b010:  value[0] = $signed(a) < $signed(b);
        3'b011:  value[0] = a < b;
        3'b100:  value = a ^ b;
        3'b110:  value = a | b;
        3'b111:  value = a & b;
        default: begin
            if (alt) begin
                value = $signed(a) >>> sh;
            end else begin
                value = a >> sh;
            end
        end
    endcase
    if (rd != '0) begin
        model_regs[rd] = value;
    end
    return 1'b1;
endfunction

`endif

//--- tb/tb_kiwi_core.sv
`timescale 1ns/100ps

module tb_kiwi_core;

    localparam int XLEN           = 64;
    localparam int SHW            = $clog2(XLEN);
    localparam int NUM_INST       = 400;
    localparam int TIMEOUT_CYCLES = 8 + 6 * NUM_INST;

    typedef struct packed {
        kiwi_pkg::reg_idx_t rd;
        logic [XLEN-1:0]    value;
    } wb_entry_t;

    logic               clk = 1'b0;
    logic               arst_n_i;
    logic               inst_valid_i;
    kiwi_pkg::inst_u    inst_i;
    logic               inst_ready_o;
    logic               wb_valid_o;
    kiwi_pkg::reg_idx_t wb_rd_o;
    logic [XLEN-1:0]    wb_value_o;

    wb_entry_t exp_q [$];
    wb_entry_t popped;
    int        mismatches;
    int        unexpected_wb;
    int        other_errors;
    int        n_sent;
    int        n_supported;
    int        n_wb;
    int        cycle_count;

    `include "tb_kiwi_ref.svh"

    kiwi_core #(
        .XLEN (XLEN)
    ) i_dut (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .inst_ready_o (inst_ready_o),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_value_o   (wb_value_o)
    );

    always #5 clk = ~clk;

    task automatic check_rd(input kiwi_pkg::reg_idx_t exp, input kiwi_pkg::reg_idx_t act);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch at %0t: wb_rd_o expected x%0d, got x%0d", $time, exp, act);
        end
    endtask

    task automatic check_value(input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch at %0t: wb_value_o expected %h, got %h", $time, exp, act);
        end
    endtask

    // word is held until an edge sees ready high
    task automatic send_inst(input kiwi_pkg::inst_u w);
        logic               accepted;
        kiwi_pkg::reg_idx_t rd_exp;
        logic [XLEN-1:0]    value_exp;
        inst_valid_i = 1'b1;
        inst_i       = w;
        accepted     = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = inst_ready_o;
            @(posedge clk);
            #1;
        end
        inst_valid_i = 1'b0;
        n_sent++;
        if (ref_execute(w, rd_exp, value_exp)) begin
            n_supported++;
            exp_q.push_back('{rd: rd_exp, value: value_exp});
        end
    endtask

    task automatic idle_cycles(input int n);
        inst_valid_i = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // random register value built by a chain of dependent shifts and xors
    task automatic load_random_reg(input kiwi_pkg::reg_idx_t r);
        send_inst(imm_inst(0, 5'd0, 12'(rand_bits(12)), r));
        repeat (5) begin
            send_inst(imm_inst(6, r, 12'd11, r));
            send_inst(imm_inst(3, r, {1'b0, 11'(rand_bits(11))}, r));
        end
    endtask

    always @(negedge clk) begin
        if (arst_n_i === 1'b1 && wb_valid_o === 1'b1) begin
            n_wb++;
            if (exp_q.size() == 0) begin
                unexpected_wb++;
                $display("write-back to x%0d at %0t with no instruction waiting for it",
                         wb_rd_o, $time);
            end else begin
                popped = exp_q.pop_front();
                check_rd(popped.rd, wb_rd_o);
                check_value(popped.value, wb_value_o);
            end
        end
    end

    initial begin
        kiwi_pkg::inst_u w;
        lfsr_state   = 32'd70753;
        arst_n_i     = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        for (int i = 0; i < kiwi_pkg::NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        @(negedge clk);
        if (wb_valid_o !== 1'b0 || inst_ready_o !== 1'b1) begin
            other_errors++;
            $display("after reset wb_valid_o is %b and inst_ready_o is %b instead of 0 and 1",
                     wb_valid_o, inst_ready_o);
        end
        @(posedge clk);
        #1;
        for (int r = 1; r <= 8; r++) begin
            load_random_reg(5'(r));
        end
        repeat (4) begin
            for (int k = 0; k < 10; k++) begin
                send_inst(op_inst(k, rand_reg(), rand_reg(), rand_reg()));
            end
        end
        repeat (4) begin
            for (int k = 0; k < 9; k++) begin
                send_inst(imm_inst(k, rand_reg(), 12'(rand_bits(12)), rand_reg()));
            end
        end
        // back-to-back dependent chain through x20
        for (int k = 0; k < 30; k++) begin
            if (k % 2 == 1) begin
                send_inst(op_inst(k % 10, 5'd20, rand_reg(), 5'd20));
            end else begin
                send_inst(imm_inst(k % 9, 5'd20, 12'(rand_bits(12)), 5'd20));
            end
        end
        repeat (8) begin
            send_inst(other_inst());
        end
        w          = op_inst(0, 5'd1, 5'd2, 5'd3);
        w.r.funct7 = 7'b0000001;
        send_inst(w);
        w          = op_inst(5, 5'd1, 5'd2, 5'd3);
        w.r.funct7 = 7'b0100000;
        send_inst(w);
        // writes to x0 and later reads of x0
        send_inst(op_inst(0, 5'd1, 5'd2, 5'd0));
        send_inst(imm_inst(0, 5'd3, 12'h7ff, 5'd0));
        // both writes pass the register file before the reads issue
        idle_cycles(3);
        send_inst(op_inst(0, 5'd0, 5'd0, 5'd22));
        send_inst(op_inst(8, 5'd0, 5'd1, 5'd23));
        while (n_sent < NUM_INST) begin
            idle_cycles(int'(rand_bits(2)));
            case (3'(rand_bits(3)))
                3'd0:          send_inst(other_inst());
                3'd1, 3'd3:    send_inst(imm_inst(int'(rand_bits(4)) % 9, rand_reg(),
                                                  12'(rand_bits(12)), rand_reg()));
                default:       send_inst(op_inst(int'(rand_bits(4)) % 10, rand_reg(),
                                                 rand_reg(), rand_reg()));
            endcase
        end
        for (int c = 0; c < 20 && exp_q.size() != 0; c++) begin
            @(posedge clk);
        end
        // a few more cycles so that a stray write-back still shows up
        repeat (4) @(posedge clk);
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("%0d expected write-backs never arrived", exp_q.size());
        end
        if (n_wb != n_supported) begin
            other_errors++;
            $display("%0d write-backs seen for %0d supported instructions", n_wb, n_supported);
        end
        $display("errors: %0d mismatches, %0d unexpected write-backs, %0d other",
                 mismatches, unexpected_wb, other_errors);
        if (mismatches + unexpected_wb + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles with %0d of %0d instructions sent",
                 cycle_count, n_sent, NUM_INST);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- flist.f
+incdir+tb
verilog/kiwi_pkg.sv
verilog/kiwi_if.sv
verilog/kiwi_decoder.sv
verilog/kiwi_scoreboard.sv
verilog/kiwi_operands.sv
verilog/kiwi_alu.sv
verilog/kiwi_core.sv
tb/tb_kiwi_core.sv
